/* run_sim.sh */
#!/bin/sh
# build and run the text video testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f text_video.f --top-module tb_text_video
out=$(./obj_dir/Vtb_text_video)
echo "$out"
if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1

/* text_video.f */
verilog/text_video_pkg.sv
verilog/sync_timer.sv
verilog/cmd_decoder.sv
verilog/text_mem.sv
verilog/glyph_pixel_gen.sv
verilog/text_video_top.sv
verif/tb_video_checker.sv
verif/tb_text_video.sv

/* verif/tb_text_video.sv */
//////////////////////////////////////////////////////////////////////
// testbench top; commands go out right after a vsync fall so every
// load lands before the next visible region
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_text_video;

  import text_video_pkg::*;

  logic       clk;
  logic       rst_n;
  logic       cmd_valid;
  logic [7:0] cmd_data;
  logic       hsync;
  logic       vsync;
  logic       de;
  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;
  logic       bad_cmd;
  logic       exp_valid;
  int         exp_fg;
  int         pixel_errors;
  int         sync_errors;
  int         count_errors;
  int         frames;

  // vectors and run control
  string   names[$];
  string   acts[$];
  int      vals[$];
  int      tb_errors;
  longint  cycles;
  longint  limit;

  always #4 clk = ~clk;

  text_video_top dut_i (.clk, .rst_n, .cmd_valid, .cmd_data, .hsync, .vsync, .de,
                        .red, .green, .blue, .bad_cmd);

  tb_video_checker checker_i (.clk, .rst_n, .cmd_valid, .cmd_data, .hsync, .vsync, .de,
                              .red, .green, .blue, .bad_cmd, .exp_valid, .exp_fg,
                              .pixel_errors, .sync_errors, .count_errors, .frames);

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic read_vectors();
    int    fd;
    int    n;
    int    v;
    string line;
    string nm;
    string ac;
    fd = $fopen("verif/text_video_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the vectors file");
      tb_errors++;
      return;
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      // skip blank and comment lines
      if (n < 2 || line.getc(0) == 8'h23)
        continue;
      n = $sscanf(line, "%s %s %h", nm, ac, v);
      if (n == 3)
      begin
        names.push_back(nm);
        acts.push_back(ac);
        vals.push_back(v);
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_frame_start();
    @(negedge vsync);
    @(negedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b);
    cmd_valid = 1'b1;
    cmd_data  = b;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // opcode then all font bytes on consecutive cycles, byte = address ^ seed
  task automatic send_font(input logic [7:0] seed);
    logic [7:0] a;
    cmd_valid = 1'b1;
    cmd_data  = 8'h80;
    for (int i = 0; i < FONT_BYTES; i++)
    begin
      @(negedge clk);
      a = 8'(i);
      cmd_data = a ^ seed;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // byte = address * mult, low 8 bits
  task automatic send_chars(input logic [7:0] mult);
    logic [7:0] a;
    cmd_valid = 1'b1;
    cmd_data  = 8'h82;
    for (int i = 0; i < CHAR_BYTES; i++)
    begin
      @(negedge clk);
      a = 8'(i);
      cmd_data = a * mult;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // two frame starts, so the frame between them is whole
  task automatic request_fg_check(input int v);
    int f0;
    f0 = frames;
    while (frames < f0 + 2)
      @(negedge clk);
    exp_fg    = v;
    exp_valid = 1'b1;
    @(negedge clk);
    exp_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int total;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_data  = 8'h00;
    exp_valid = 1'b0;
    exp_fg    = 0;
    tb_errors = 0;
    cycles    = 0;
    limit     = 0;
    read_vectors();
    // a frame per vector line on average plus three spare frames, doubled for margin
    limit = 2 * (longint'(names.size()) + 3) * H_TOTAL * V_TOTAL;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < names.size(); i++)
    begin
      checker_i.test_name = names[i];
      case (acts[i])
        "send":
        begin
          wait_frame_start();
          send_byte(8'(vals[i]));
        end
        "font":
        begin
          wait_frame_start();
          send_font(8'(vals[i]));
        end
        "chars":
        begin
          wait_frame_start();
          send_chars(8'(vals[i]));
        end
        "expect": request_fg_check(vals[i]);
        default:
        begin
          tb_errors++;
          $display("unknown action %s in test %s", acts[i], names[i]);
        end
      endcase
    end
    if (names.size() == 0 || frames == 0)
    begin
      tb_errors++;
      $display("no vectors run or no whole frame seen");
    end
    total = pixel_errors + sync_errors + count_errors + tb_errors;
    $display("errors: pixel %0d sync %0d count %0d testbench %0d", pixel_errors, sync_errors,
             count_errors, tb_errors);
    if (total == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // cycle limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_video_checker.sv */
//////////////////////////////////////////////////////////////////////
// watches the command port and video outputs; pixels are checked only
// in frames that start with both memories fully loaded
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_video_checker
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_valid,
  input  logic [7:0] cmd_data,
  input  logic       hsync,
  input  logic       vsync,
  input  logic       de,
  input  logic [3:0] red,
  input  logic [3:0] green,
  input  logic [3:0] blue,
  input  logic       bad_cmd,
  input  logic       exp_valid,
  input  int         exp_fg,
  output int         pixel_errors,
  output int         sync_errors,
  output int         count_errors,
  output int         frames
);

  import text_video_pkg::*;

  // name of the running test, set by the testbench top
  string test_name;

  // reference copies of both memories and of the decoder
  logic [7:0] font_m [FONT_BYTES];
  logic [7:0] chars_m [CHAR_BYTES];
  cmd_state_e m_state;
  int         m_cnt;
  logic       m_bad;
  logic       font_ok;
  logic       chars_ok;

  // raster tracking
  logic hs_q;
  logic vs_q;
  int   h_cyc;
  int   h_low;
  int   v_cyc;
  int   v_low;
  bit   v_seen;
  bit   armed;
  int   k;
  int   de_cnt;
  int   fg_cnt;
  int   last_fg;

  //////////////////////////////////////////////////////////////////////
  // command model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      m_state  <= CMD_IDLE;
      m_cnt    <= 0;
      m_bad    <= 1'b0;
      font_ok  <= 1'b0;
      chars_ok <= 1'b0;
    end
    else if (cmd_valid)
    begin
      case (m_state)
        CMD_IDLE:
        begin
          m_cnt <= 0;
          if (cmd_data == 8'h80)
            m_state <= CMD_FONT_DATA;
          else if (cmd_data == 8'h82)
            m_state <= CMD_CHAR_DATA;
          else
            m_bad <= 1'b1;
        end
        CMD_FONT_DATA:
        begin
          font_m[m_cnt] <= cmd_data;
          m_cnt <= m_cnt + 1;
          if (m_cnt == FONT_BYTES - 1)
          begin
            m_state <= CMD_IDLE;
            font_ok <= 1'b1;
          end
        end
        default:
        begin
          chars_m[m_cnt] <= cmd_data;
          m_cnt <= m_cnt + 1;
          if (m_cnt == CHAR_BYTES - 1)
          begin
            m_state  <= CMD_IDLE;
            chars_ok <= 1'b1;
          end
        end
      endcase
    end
  end

  // foreground count of the last whole frame
  always @(posedge clk)
  begin
    if (exp_valid && last_fg != exp_fg)
    begin
      count_errors <= count_errors + 1;
      $display("error %s: fg count expected %0d actual %0d", test_name, exp_fg, last_fg);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // video checks, sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    int         x;
    int         y;
    logic [7:0] code;
    logic [7:0] gbyte;
    logic [11:0] exp_rgb;
    if (!rst_n)
    begin
      if (!hsync || !vsync || de || {red, green, blue} != 12'h000 || bad_cmd)
      begin
        sync_errors++;
        // fields are hsync, vsync, de, rgb, bad_cmd
        $display("error reset: outputs expected 1 1 0 000 0 actual %b %b %b %h %b", hsync,
                 vsync, de, {red, green, blue}, bad_cmd);
      end
      hs_q = 1'b1;
      vs_q = 1'b1;
      h_cyc = 0;
      h_low = 0;
      v_cyc = 0;
      v_low = 0;
      v_seen = 0;
      armed = 0;
    end
    else
    begin
      h_cyc++;
      v_cyc++;
      // hsync period and width
      if (hs_q && !hsync)
      begin
        if (h_cyc != H_TOTAL && v_seen)
        begin
          sync_errors++;
          $display("error %s: hsync period expected %0d actual %0d", test_name, H_TOTAL, h_cyc);
        end
        h_cyc = 0;
      end
      if (!hsync)
        h_low++;
      if (!hs_q && hsync)
      begin
        if (h_low != H_SYNC)
        begin
          sync_errors++;
          $display("error %s: hsync width expected %0d actual %0d", test_name, H_SYNC, h_low);
        end
        h_low = 0;
      end
      // vsync edges, a fall starts a new frame
      if (!vsync)
        v_low++;
      if (!vs_q && vsync)
      begin
        if (v_low != V_SYNC * H_TOTAL)
        begin
          sync_errors++;
          $display("error %s: vsync width expected %0d actual %0d", test_name,
                   V_SYNC * H_TOTAL, v_low);
        end
        v_low = 0;
      end
      if (vs_q && !vsync)
      begin
        if (v_seen)
        begin
          if (v_cyc != V_TOTAL * H_TOTAL)
          begin
            sync_errors++;
            $display("error %s: vsync period expected %0d actual %0d", test_name,
                     V_TOTAL * H_TOTAL, v_cyc);
          end
          if (de_cnt != H_VISIBLE * V_VISIBLE)
          begin
            sync_errors++;
            $display("error %s: de cycles expected %0d actual %0d", test_name,
                     H_VISIBLE * V_VISIBLE, de_cnt);
          end
          last_fg = fg_cnt;
          frames++;
        end
        v_seen = 1;
        v_cyc = 0;
        k = 0;
        de_cnt = 0;
        fg_cnt = 0;
        armed = font_ok && chars_ok;
      end
      // pixels, numbered in de order
      if (de)
      begin
        if ({red, green, blue} == {FG_RED, FG_GREEN, FG_BLUE})
          fg_cnt++;
        if (armed)
        begin
          x = k % H_VISIBLE;
          y = k / H_VISIBLE;
          code = chars_m[(y / GLYPH_H) * TEXT_COLS + x / GLYPH_W];
          gbyte = font_m[(code % 16) * GLYPH_H + y % GLYPH_H];
          if (gbyte[7 - x % 8])
            exp_rgb = {FG_RED, FG_GREEN, FG_BLUE};
          else
            exp_rgb = {BG_RED, BG_GREEN, BG_BLUE};
          if ({red, green, blue} != exp_rgb)
          begin
            pixel_errors++;
            $display("error %s: pixel %0d,%0d expected %h actual %h", test_name, x, y,
                     exp_rgb, {red, green, blue});
          end
        end
        k++;
        de_cnt++;
      end
      else if ({red, green, blue} != 12'h000)
      begin
        pixel_errors++;
        $display("error %s: blank rgb expected 000 actual %h", test_name, {red, green, blue});
      end
      if (bad_cmd != m_bad)
      begin
        sync_errors++;
        $display("error %s: bad_cmd expected %b actual %b", test_name, m_bad, bad_cmd);
      end
      hs_q = hsync;
      vs_q = vsync;
    end
  end

endmodule

`default_nettype wire

/* verif/text_video_vectors.txt */
# columns: test name, action (send, font, chars, expect), value in hex
# font: seed xored onto each address; chars: multiplier per address; expect: fg pixels
load_font font 00
load_chars chars 03
glyph_display expect 400
char_reload chars 02
char_reload expect 380
font_reload font 50
font_reload expect 480
bad_opcode send 41
bad_opcode expect 480
opcode_after_bad chars 03
opcode_after_bad expect 400
back_to_back chars 06
back_to_back expect 480

/* verilog/cmd_decoder.sv */
//////////////////////////////////////////////////////////////////////
// command byte decoder, one byte per cmd_valid strobe, no back-pressure;
// bytes inside a load are always data, opcodes only count in idle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   cmd_valid,
  input  logic [text_video_pkg::BYTE_W-1:0]      cmd_data,
  output logic                                   font_we,
  output logic [text_video_pkg::FONT_ADDR_W-1:0] font_waddr,
  output logic [text_video_pkg::BYTE_W-1:0]      font_wdata,
  output logic                                   char_we,
  output logic [text_video_pkg::CHAR_ADDR_W-1:0] char_waddr,
  output logic [text_video_pkg::BYTE_W-1:0]      char_wdata,
  output logic                                   bad_cmd
);

  import text_video_pkg::*;

  cmd_state_e state;

  // byte counter, sized for the larger font load
  logic [FONT_ADDR_W-1:0] byte_cnt;
  logic                   last_font;
  logic                   last_char;

  // write address and data, shared by both memory ports
  logic [FONT_ADDR_W-1:0] wr_addr;
  logic [BYTE_W-1:0]      wr_data;

  assign last_font = (byte_cnt == FONT_ADDR_W'(FONT_BYTES - 1));
  assign last_char = (byte_cnt == FONT_ADDR_W'(CHAR_BYTES - 1));

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= CMD_IDLE;
      byte_cnt <= '0;
      font_we  <= 1'b0;
      char_we  <= 1'b0;
      bad_cmd  <= 1'b0;
    end
    else
    begin
      // write strobes last a single cycle
      font_we <= 1'b0;
      char_we <= 1'b0;
      if (cmd_valid)
      begin
        case (state)
          CMD_IDLE:
          begin
            byte_cnt <= '0;
            case (cmd_data)
              OP_LOAD_FONT:  state <= CMD_FONT_DATA;
              OP_LOAD_CHARS: state <= CMD_CHAR_DATA;
              // unknown byte is dropped, flag is sticky until reset
              default:       bad_cmd <= 1'b1;
            endcase
          end
          CMD_FONT_DATA:
          begin
            font_we  <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
            if (last_font)
              state <= CMD_IDLE;
          end
          CMD_CHAR_DATA:
          begin
            char_we  <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
            if (last_char)
              state <= CMD_IDLE;
          end
          default: state <= CMD_IDLE;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // capture every byte; only the strobes decide what gets written
  always_ff @(posedge clk)
  begin
    if (cmd_valid)
    begin
      wr_addr <= byte_cnt;
      wr_data <= cmd_data;
    end
  end

  assign font_waddr = wr_addr;
  assign font_wdata = wr_data;
  // character memory is small, low counter bits only
  assign char_waddr = wr_addr[CHAR_ADDR_W-1:0];
  assign char_wdata = wr_data;

endmodule

`default_nettype wire

/* verilog/glyph_pixel_gen.sv */
//////////////////////////////////////////////////////////////////////
// character fetch, glyph fetch and pixel shifter; outputs trail hcount
// by PIXEL_LATENCY cycles, fetch phases assume 8-pixel cells
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glyph_pixel_gen
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [text_video_pkg::HCOUNT_W-1:0]    hcount,
  input  logic [text_video_pkg::VCOUNT_W-1:0]    vcount,
  input  logic                                   line_visible,
  input  logic                                   frame_visible,
  input  logic                                   hsync_in,
  input  logic                                   vsync_in,
  output logic [text_video_pkg::CHAR_ADDR_W-1:0] char_raddr,
  input  logic [text_video_pkg::BYTE_W-1:0]      char_rdata,
  output logic [text_video_pkg::FONT_ADDR_W-1:0] font_raddr,
  input  logic [text_video_pkg::BYTE_W-1:0]      font_rdata,
  output logic [3:0]                             red,
  output logic [3:0]                             green,
  output logic [3:0]                             blue,
  output logic                                   hsync,
  output logic                                   vsync,
  output logic                                   de
);

  import text_video_pkg::*;

  // pixel position inside the current cell
  logic [2:0]             phase;
  // cell and line whose character code is fetched next
  logic [CHAR_ADDR_W-1:0] fetch_col;
  logic [VCOUNT_W-1:0]    fetch_line;
  // glyph row being shifted out, msb is the leftmost pixel
  logic [GLYPH_W-1:0]     pix_shift;
  // delay lines, the output registers make the last stage
  logic [PIXEL_LATENCY-2:0] vis_pipe;
  logic [PIXEL_LATENCY-2:0] hs_pipe;
  logic [PIXEL_LATENCY-2:0] vs_pipe;

  assign phase = hcount[2:0];

  //////////////////////////////////////////////////////////////////////
  // fetch pipeline
  //////////////////////////////////////////////////////////////////////

  // cell c: char address at phase 6 of cell c-1, glyph address at phase 0,
  // shifter load at phase 2, so pixel 8c reaches the colour regs at 8c+4
  always_comb
  begin
    if (hcount == HCOUNT_W'(H_TOTAL - 2))
    begin
      // prefetch for column 0 of the next line
      fetch_col  = '0;
      fetch_line = (vcount == VCOUNT_W'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
    end
    else
    begin
      // cells past the visible width fetch harmless junk
      fetch_col  = CHAR_ADDR_W'(hcount / GLYPH_W + 1);
      fetch_line = vcount;
    end
  end

  always_ff @(posedge clk)
  begin
    if (phase == 3'd6)
      char_raddr <= CHAR_ADDR_W'((fetch_line / GLYPH_H) * TEXT_COLS + fetch_col);
    // low 4 bits of the code select one of the 16 glyphs
    if (phase == 3'd0)
      font_raddr <= FONT_ADDR_W'({char_rdata[3:0], vcount[3:0]});
    if (phase == 3'd2)
      pix_shift <= font_rdata;
    else
      pix_shift <= pix_shift << 1;
  end

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vis_pipe <= '0;
      hs_pipe  <= '1;
      vs_pipe  <= '1;
      de       <= 1'b0;
      hsync    <= 1'b1;
      vsync    <= 1'b1;
      red      <= 4'h0;
      green    <= 4'h0;
      blue     <= 4'h0;
    end
    else
    begin
      // syncs ride the same delay as the pixels
      vis_pipe <= {vis_pipe[PIXEL_LATENCY-3:0], line_visible & frame_visible};
      hs_pipe  <= {hs_pipe[PIXEL_LATENCY-3:0], hsync_in};
      vs_pipe  <= {vs_pipe[PIXEL_LATENCY-3:0], vsync_in};
      de       <= vis_pipe[PIXEL_LATENCY-2];
      hsync    <= hs_pipe[PIXEL_LATENCY-2];
      vsync    <= vs_pipe[PIXEL_LATENCY-2];
      if (!vis_pipe[PIXEL_LATENCY-2])
        {red, green, blue} <= 12'h000;
      else if (pix_shift[GLYPH_W-1])
        {red, green, blue} <= {FG_RED, FG_GREEN, FG_BLUE};
      else
        {red, green, blue} <= {BG_RED, BG_GREEN, BG_BLUE};
    end
  end

endmodule

`default_nettype wire

/* verilog/sync_timer.sv */
//////////////////////////////////////////////////////////////////////
// free-running raster counters; syncs and visible flags are decoded
// straight from the counters, so they carry no extra latency
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sync_timer
(
  input  logic                                clk,
  input  logic                                rst_n,
  output logic [text_video_pkg::HCOUNT_W-1:0] hcount,
  output logic [text_video_pkg::VCOUNT_W-1:0] vcount,
  output logic                                line_visible,
  output logic                                frame_visible,
  output logic                                hsync,
  output logic                                vsync
);

  import text_video_pkg::*;

  // end of line and end of frame
  logic h_last;
  logic v_last;

  assign h_last = (hcount == HCOUNT_W'(H_TOTAL - 1));
  assign v_last = (vcount == VCOUNT_W'(V_TOTAL - 1));

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  // hcount every cycle, vcount once per line at the wrap
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hcount <= '0;
      vcount <= '0;
    end
    else if (h_last)
    begin
      hcount <= '0;
      if (v_last)
        vcount <= '0;
      else
        vcount <= vcount + 1'b1;
    end
    else
      hcount <= hcount + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////////////////////////

  // visible pixels sit at the start of each line and frame
  assign line_visible  = (hcount < HCOUNT_W'(H_VISIBLE));
  assign frame_visible = (vcount < VCOUNT_W'(V_VISIBLE));

  // sync pulses follow the front porch, both active low
  assign hsync = !((hcount >= HCOUNT_W'(H_VISIBLE + H_FRONT)) &&
                   (hcount <  HCOUNT_W'(H_VISIBLE + H_FRONT + H_SYNC)));
  // whole lines, so vsync edges line up with hcount = 0
  assign vsync = !((vcount >= VCOUNT_W'(V_VISIBLE + V_FRONT)) &&
                   (vcount <  VCOUNT_W'(V_VISIBLE + V_FRONT + V_SYNC)));

endmodule

`default_nettype wire

/* verilog/text_mem.sv */
//////////////////////////////////////////////////////////////////////
// byte-wide memory, one write port and one registered read port;
// same-address read and write in one cycle returns the old byte
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module text_mem
#(
  parameter int DEPTH  = text_video_pkg::FONT_BYTES,
  parameter int ADDR_W = text_video_pkg::FONT_ADDR_W
)
(
  input  logic                              clk,
  input  logic                              we,
  input  logic [ADDR_W-1:0]                 waddr,
  input  logic [text_video_pkg::BYTE_W-1:0] wdata,
  input  logic [ADDR_W-1:0]                 raddr,
  output logic [text_video_pkg::BYTE_W-1:0] rdata
);

  import text_video_pkg::*;

  // contents are undefined until loaded
  logic [BYTE_W-1:0] mem [DEPTH];

  // one cycle read latency
  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* verilog/text_video_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared timing, memory geometry, colours and encodings for the text
// video generator; cells are 8 pixels wide and H_TOTAL is a multiple of 8
//////////////////////////////////////////////////////////////////////
`default_nettype none

package text_video_pkg;

  //////////////////////////////////////////////////////////////////////
  // raster timing, kept tiny so a simulation covers whole frames
  //////////////////////////////////////////////////////////////////////
  localparam int H_VISIBLE = 64;
  localparam int H_FRONT   = 4;
  localparam int H_SYNC    = 8;
  localparam int H_BACK    = 4;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_VISIBLE = 32;
  localparam int V_FRONT   = 2;
  localparam int V_SYNC    = 3;
  localparam int V_BACK    = 3;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  // both counters need 7 bits (80 pixels, 40 lines)
  localparam int HCOUNT_W = 7;
  localparam int VCOUNT_W = 7;

  // character cell geometry
  localparam int GLYPH_W   = 8;
  localparam int GLYPH_H   = 16;
  localparam int TEXT_COLS = 8;
  localparam int TEXT_ROWS = 2;

  // memory sizes
  localparam int BYTE_W      = 8;
  localparam int CHAR_BYTES  = TEXT_COLS * TEXT_ROWS;
  localparam int CHAR_ADDR_W = 4;
  localparam int GLYPHS      = 16;
  localparam int FONT_BYTES  = GLYPHS * GLYPH_H;
  localparam int FONT_ADDR_W = 8;

  // cycles from hcount to the matching rgb/de/sync outputs
  localparam int PIXEL_LATENCY = 4;

  // yellow text on a dark purple background
  localparam logic [3:0] FG_RED   = 4'hf;
  localparam logic [3:0] FG_GREEN = 4'hf;
  localparam logic [3:0] FG_BLUE  = 4'h0;
  localparam logic [3:0] BG_RED   = 4'h2;
  localparam logic [3:0] BG_GREEN = 4'h0;
  localparam logic [3:0] BG_BLUE  = 4'h8;

  // command opcodes; anything else in idle is a bad command
  typedef enum logic [7:0] {
    OP_NONE       = 8'h00,
    OP_LOAD_FONT  = 8'h80,
    OP_LOAD_CHARS = 8'h82
  } cmd_opcode_e;

  // command decoder states
  typedef enum logic [1:0] {
    CMD_IDLE      = 2'd0,
    CMD_FONT_DATA = 2'd1,
    CMD_CHAR_DATA = 2'd2
  } cmd_state_e;

endpackage

`default_nettype wire

/* verilog/text_video_top.sv */
//////////////////////////////////////////////////////////////////////
// text video generator top; the command port is synchronous to clk and
// both memories hold junk until the host loads them
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module text_video_top
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cmd_valid,
  input  logic [text_video_pkg::BYTE_W-1:0] cmd_data,
  output logic                              hsync,
  output logic                              vsync,
  output logic                              de,
  output logic [3:0]                        red,
  output logic [3:0]                        green,
  output logic [3:0]                        blue,
  output logic                              bad_cmd
);

  import text_video_pkg::*;

  // raster position and undelayed syncs
  logic [HCOUNT_W-1:0]    hcount;
  logic [VCOUNT_W-1:0]    vcount;
  logic                   line_visible;
  logic                   frame_visible;
  logic                   raw_hsync;
  logic                   raw_vsync;
  // glyph memory ports
  logic                   font_we;
  logic [FONT_ADDR_W-1:0] font_waddr;
  logic [BYTE_W-1:0]      font_wdata;
  logic [FONT_ADDR_W-1:0] font_raddr;
  logic [BYTE_W-1:0]      font_rdata;
  // character memory ports
  logic                   char_we;
  logic [CHAR_ADDR_W-1:0] char_waddr;
  logic [BYTE_W-1:0]      char_wdata;
  logic [CHAR_ADDR_W-1:0] char_raddr;
  logic [BYTE_W-1:0]      char_rdata;

  sync_timer timer_i (.clk, .rst_n, .hcount, .vcount, .line_visible, .frame_visible,
                      .hsync(raw_hsync), .vsync(raw_vsync));

  cmd_decoder decoder_i (.clk, .rst_n, .cmd_valid, .cmd_data, .font_we, .font_waddr,
                         .font_wdata, .char_we, .char_waddr, .char_wdata, .bad_cmd);

  // font, 16 glyphs of 16 rows
  text_mem #(.DEPTH(FONT_BYTES), .ADDR_W(FONT_ADDR_W)) glyph_mem_i (
    .clk, .we(font_we), .waddr(font_waddr), .wdata(font_wdata),
    .raddr(font_raddr), .rdata(font_rdata));

  // screen text, one code per cell
  text_mem #(.DEPTH(CHAR_BYTES), .ADDR_W(CHAR_ADDR_W)) char_mem_i (
    .clk, .we(char_we), .waddr(char_waddr), .wdata(char_wdata),
    .raddr(char_raddr), .rdata(char_rdata));

  glyph_pixel_gen pixel_gen_i (.clk, .rst_n, .hcount, .vcount, .line_visible,
                               .frame_visible, .hsync_in(raw_hsync), .vsync_in(raw_vsync),
                               .char_raddr, .char_rdata, .font_raddr, .font_rdata,
                               .red, .green, .blue, .hsync, .vsync, .de);

endmodule

`default_nettype wire
